//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_tensor_sched
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/burst_table.sv
module burst_table (
    input  tensor_sched_pkg::mat_t        mat,
    input  tensor_sched_pkg::shape_t      shape,
    input  tensor_sched_pkg::dtype_t      dtype,
    input  logic                          mixed,
    output tensor_sched_pkg::burst_num_t  burst_num,
    output tensor_sched_pkg::burst_size_t burst_size
);
    import tensor_sched_pkg::*;

    burst_num_t  a_max;   // A beats for FP32, halves per narrower type
    burst_size_t c_size;
    burst_num_t  b_num;
    burst_size_t b_size;

    always_comb begin
        case (shape)
            M16K16N16: a_max = 6'd31;
            M8K16N32:  a_max = 6'd15;
            default:   a_max = 6'd63;
        endcase
    end

    always_comb begin
        case (dtype)
            FP32:    c_size = 3'd5;
            FP16:    c_size = mixed ? 3'd5 : 3'd4;  // FP32 accumulators when mixed
            INT8:    c_size = 3'd3;
            default: c_size = 3'd2;
        endcase
    end

    always_comb begin
        case ({shape, dtype})
            {M32K16N8, FP32}:  {b_num, b_size} = {6'd15, 3'd5};
            {M32K16N8, FP16}:  {b_num, b_size} = {6'd15, 3'd4};
            {M32K16N8, INT8}:  {b_num, b_size} = {6'd15, 3'd3};
            {M32K16N8, INT4}:  {b_num, b_size} = {6'd15, 3'd2};
            {M16K16N16, FP32}: {b_num, b_size} = {6'd31, 3'd5};
            {M16K16N16, FP16}: {b_num, b_size} = {6'd15, 3'd5};
            {M16K16N16, INT8}: {b_num, b_size} = {6'd15, 3'd4};
            {M16K16N16, INT4}: {b_num, b_size} = {6'd15, 3'd3};
            {M8K16N32, FP32}:  {b_num, b_size} = {6'd63, 3'd5};
            {M8K16N32, FP16}:  {b_num, b_size} = {6'd31, 3'd5};
            {M8K16N32, INT8}:  {b_num, b_size} = {6'd15, 3'd5};
            {M8K16N32, INT4}:  {b_num, b_size} = {6'd15, 3'd4};
            default:           {b_num, b_size} = {6'd15, 3'd5};
        endcase
    end

    always_comb begin
        case (mat)
            MAT_A: begin
                burst_num  = a_max >> dtype;
                burst_size = 3'd5;  // Always full 32-byte beats
            end
            MAT_B: begin
                burst_num  = b_num;
                burst_size = b_size;
            end
            default: begin
                burst_num  = 6'd31;
                burst_size = c_size;
            end
        endcase
    end
endmodule

//--- hdl/load_if.sv
interface load_if;
    import tensor_sched_pkg::*;

    logic issue;      // One-cycle load request
    logic load_done;  // One-cycle end of load
    logic busy;
    mat_t mat;

    modport sequencer (
        output issue,
        output mat,
        input  load_done,
        input  busy
    );

    modport requester (
        input  issue,
        input  mat,
        output load_done,
        output busy
    );
endinterface

//--- hdl/phase_sequencer.sv
`include "tensor_sched_params.svh"

module phase_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  tensor_sched_pkg::dtype_t dtype,
    load_if.sequencer                lif,
    output logic                     compute_en,
    output logic                     accumulate_en,
    output logic                     writeback_en,
    output logic                     done
);
    import tensor_sched_pkg::*;

    phase_t     state;
    cycle_cnt_t cnt;
    cycle_cnt_t compute_len;
    logic       issue_q;
    mat_t       mat_q;

    always_comb begin
        case (dtype)
            INT8:    compute_len = `COMPUTE_INT8;
            INT4:    compute_len = `COMPUTE_INT4;
            default: compute_len = `COMPUTE_FP;  // FP32 and FP16
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            cnt     <= '0;
            issue_q <= 1'b0;
        end else begin
            issue_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= LOAD_C;
                        issue_q <= 1'b1;
                        mat_q   <= MAT_C;
                    end
                end
                LOAD_C: begin
                    if (lif.load_done) begin
                        state   <= LOAD_A;
                        issue_q <= 1'b1;
                        mat_q   <= MAT_A;
                    end
                end
                LOAD_A: begin
                    if (lif.load_done) begin
                        state   <= LOAD_B;
                        issue_q <= 1'b1;
                        mat_q   <= MAT_B;
                    end
                end
                LOAD_B: begin
                    if (lif.load_done) begin
                        state <= COMPUTE;
                        cnt   <= compute_len;
                    end
                end
                COMPUTE: begin
                    cnt <= cnt - 7'd1;
                    if (cnt == '0) begin
                        state <= (dtype == INT4) ? ACCUMULATE : WRITE_BACK;
                    end
                end
                ACCUMULATE: state <= WRITE_BACK;
                WRITE_BACK: state <= FINISH;
                default:    state <= FINISH;  // Held until reset
            endcase
        end
    end

    assign lif.issue = issue_q;
    assign lif.mat   = mat_q;

    assign compute_en    = (state == COMPUTE);
    assign accumulate_en = (state == ACCUMULATE);
    assign writeback_en  = (state == WRITE_BACK);
    assign done          = (state == FINISH);

    // Requester must be free before a new load is issued
    a_issue_idle: assert property (@(posedge clk) disable iff (rst)
        lif.issue |-> !lif.busy);

    a_one_enable: assert property (@(posedge clk) disable iff (rst)
        $onehot0({compute_en, accumulate_en, writeback_en}));
endmodule

//--- hdl/read_requester.sv
`include "tensor_sched_params.svh"

module read_requester (
    input  logic                          clk,
    input  logic                          rst,
    load_if.requester                     lif,
    input  logic                          axi_in_arready,
    input  logic                          axi_in_finish,
    input  tensor_sched_pkg::burst_num_t  burst_num,
    input  tensor_sched_pkg::burst_size_t burst_size,
    output logic                          axi_out_request_valid,
    output tensor_sched_pkg::sel_t        axi_out_sel,
    output tensor_sched_pkg::addr_t       axi_out_base,
    output tensor_sched_pkg::burst_num_t  axi_out_burst_num,
    output tensor_sched_pkg::burst_size_t axi_out_burst_size,
    output tensor_sched_pkg::mat_t        table_mat
);
    import tensor_sched_pkg::*;

    sel_t  sel_d;
    addr_t base_d;
    logic  busy_q;
    logic  done_q;

    assign table_mat = lif.mat;  // Table answers in the issue cycle

    always_comb begin
        case (lif.mat)
            MAT_A: begin
                sel_d  = `SEL_A;
                base_d = `BASE_A;
            end
            MAT_B: begin
                sel_d  = `SEL_B;
                base_d = `BASE_B;
            end
            default: begin
                sel_d  = `SEL_C;
                base_d = `BASE_C;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (lif.issue) begin
            axi_out_sel        <= sel_d;
            axi_out_base       <= base_d;
            axi_out_burst_num  <= burst_num;
            axi_out_burst_size <= burst_size;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            axi_out_request_valid <= 1'b0;
            busy_q                <= 1'b0;
            done_q                <= 1'b0;
        end else begin
            done_q <= busy_q && axi_in_finish;
            if (lif.issue) begin
                axi_out_request_valid <= 1'b1;
                busy_q                <= 1'b1;
            end else if (busy_q && axi_in_finish) begin
                axi_out_request_valid <= 1'b0;  // Finish wins over a pending request
                busy_q                <= 1'b0;
            end else if (axi_in_arready) begin
                axi_out_request_valid <= 1'b0;
            end
        end
    end

    assign lif.busy      = busy_q;
    assign lif.load_done = done_q;

    a_hold_fields: assert property (@(posedge clk) disable iff (rst)
        axi_out_request_valid && !axi_in_arready |=>
            $stable({axi_out_sel, axi_out_base, axi_out_burst_num, axi_out_burst_size}));

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        axi_out_request_valid |-> $onehot(axi_out_sel));
endmodule

//--- hdl/tensor_sched.sv
module tensor_sched (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  tensor_sched_pkg::shape_t      shape,
    input  tensor_sched_pkg::dtype_t      dtype,
    input  logic                          mixed,
    input  logic                          axi_in_arready,
    input  logic                          axi_in_finish,
    output logic                          axi_out_request_valid,
    output tensor_sched_pkg::sel_t        axi_out_sel,
    output tensor_sched_pkg::addr_t       axi_out_base,
    output tensor_sched_pkg::burst_num_t  axi_out_burst_num,
    output tensor_sched_pkg::burst_size_t axi_out_burst_size,
    output logic                          compute_en,
    output logic                          accumulate_en,
    output logic                          writeback_en,
    output logic                          done
);
    import tensor_sched_pkg::*;

    mat_t        table_mat;
    burst_num_t  table_num;
    burst_size_t table_size;

    load_if u_load_if ();

    phase_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .dtype         (dtype),
        .lif           (u_load_if.sequencer),
        .compute_en    (compute_en),
        .accumulate_en (accumulate_en),
        .writeback_en  (writeback_en),
        .done          (done)
    );

    read_requester u_requester (
        .clk                   (clk),
        .rst                   (rst),
        .lif                   (u_load_if.requester),
        .axi_in_arready        (axi_in_arready),
        .axi_in_finish         (axi_in_finish),
        .burst_num             (table_num),
        .burst_size            (table_size),
        .axi_out_request_valid (axi_out_request_valid),
        .axi_out_sel           (axi_out_sel),
        .axi_out_base          (axi_out_base),
        .axi_out_burst_num     (axi_out_burst_num),
        .axi_out_burst_size    (axi_out_burst_size),
        .table_mat             (table_mat)
    );

    burst_table u_table (
        .mat        (table_mat),
        .shape      (shape),
        .dtype      (dtype),
        .mixed      (mixed),
        .burst_num  (table_num),
        .burst_size (table_size)
    );
endmodule

//--- hdl/tensor_sched_params.svh
`ifndef TENSOR_SCHED_PARAMS_SVH
`define TENSOR_SCHED_PARAMS_SVH

// Base addresses of the three operand matrices
`define BASE_C 32'h0001_0000
`define BASE_A 32'h0010_0000
`define BASE_B 32'h0100_0000

// One-hot select codes on the request bus
`define SEL_C 3'b001
`define SEL_B 3'b010
`define SEL_A 3'b100

// Compute phase lengths, compute_en stays high for one cycle more
`define COMPUTE_FP   7'd64
`define COMPUTE_INT8 7'd16
`define COMPUTE_INT4 7'd8

`endif

//--- hdl/tensor_sched_pkg.sv
package tensor_sched_pkg;

    typedef enum logic [1:0] {
        M32K16N8,
        M16K16N16,
        M8K16N32
    } shape_t;

    typedef enum logic [1:0] {
        FP32,
        FP16,
        INT8,
        INT4
    } dtype_t;

    typedef enum logic [1:0] {
        MAT_C,
        MAT_A,
        MAT_B
    } mat_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_C,
        LOAD_A,
        LOAD_B,
        COMPUTE,
        ACCUMULATE,
        WRITE_BACK,
        FINISH
    } phase_t;

    typedef logic [2:0]  sel_t;
    typedef logic [31:0] addr_t;
    typedef logic [5:0]  burst_num_t;   // Beats minus one
    typedef logic [2:0]  burst_size_t;  // log2 of bytes per beat
    typedef logic [6:0]  cycle_cnt_t;

endpackage

//--- testbench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // Period of 10
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
    end
endmodule

//--- testbench/tb_tensor_sched.sv
module tb_tensor_sched;
    import tensor_sched_pkg::*;

    typedef struct packed {
        logic [2:0]  sel;
        logic [31:0] base;
        logic [5:0]  num;
        logic [2:0]  size;
        logic [6:0]  len;
    } expect_t;

    // Rows are shapes, columns are FP32, FP16, INT8, INT4
    localparam int A_NUM [3][4]  = '{'{63, 31, 15, 7}, '{31, 15, 7, 3}, '{15, 7, 3, 1}};
    localparam int B_NUM [3][4]  = '{'{15, 15, 15, 15}, '{31, 15, 15, 15}, '{63, 31, 15, 15}};
    localparam int B_SIZE [3][4] = '{'{5, 4, 3, 2}, '{5, 5, 4, 3}, '{5, 5, 5, 4}};
    localparam int C_SIZE [4]    = '{5, 4, 3, 2};
    localparam int TIMEOUT       = 100;

    logic        clk;
    logic        por_rst;
    logic        case_rst;
    logic        rst;
    logic        start;
    logic        mixed;
    logic        arready;
    logic        finish;
    shape_t      shape;
    dtype_t      dtype;
    logic        req_valid;
    sel_t        req_sel;
    addr_t       req_base;
    burst_num_t  req_num;
    burst_size_t req_size;
    logic        compute_en;
    logic        accumulate_en;
    logic        writeback_en;
    logic        done;
    int          tests = 0;
    int          failed = 0;
    int          checks = 0;
    int          errors = 0;

    assign rst = por_rst | case_rst;

    tb_clock u_clock (
        .clk (clk),
        .rst (por_rst)
    );

    tensor_sched u_dut (
        .clk                   (clk),
        .rst                   (rst),
        .start                 (start),
        .shape                 (shape),
        .dtype                 (dtype),
        .mixed                 (mixed),
        .axi_in_arready        (arready),
        .axi_in_finish         (finish),
        .axi_out_request_valid (req_valid),
        .axi_out_sel           (req_sel),
        .axi_out_base          (req_base),
        .axi_out_burst_num     (req_num),
        .axi_out_burst_size    (req_size),
        .compute_en            (compute_en),
        .accumulate_en         (accumulate_en),
        .writeback_en          (writeback_en),
        .done                  (done)
    );

    function automatic expect_t expected_request(mat_t m, shape_t s, dtype_t d, logic mx);
        expect_t e;
        e.len = (d == INT8) ? 7'd16 : (d == INT4) ? 7'd8 : 7'd64;
        case (m)
            MAT_A: begin
                e.sel  = 3'b100;
                e.base = 32'h0010_0000;
                e.num  = 6'(A_NUM[s][d]);
                e.size = 3'd5;
            end
            MAT_B: begin
                e.sel  = 3'b010;
                e.base = 32'h0100_0000;
                e.num  = 6'(B_NUM[s][d]);
                e.size = 3'(B_SIZE[s][d]);
            end
            default: begin
                e.sel  = 3'b001;
                e.base = 32'h0001_0000;
                e.num  = 6'd31;
                e.size = (d == FP16 && mx) ? 3'd5 : 3'(C_SIZE[d]);  // Wider C when mixed
            end
        endcase
        return e;
    endfunction

    task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic note_timeout(string what);
        errors++;
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        case_rst = 1'b1;
        repeat (4) next_cycle();
        case_rst = 1'b0;
    endtask

    task automatic report_test(string name, int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s ok", name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", name, errors - err0);
        end
    endtask

    // Memory side: accept after 0..5 cycles, finish 1..8 cycles later
    task automatic serve_request(mat_t m, int stall);
        expect_t e;
        int n;
        int delay;
        e = expected_request(m, shape, dtype, mixed);
        n = 0;
        while (!req_valid && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!req_valid) begin
            note_timeout($sformatf("request for %s", m.name()));
            return;
        end
        delay = (stall < 0) ? int'($urandom_range(5, 0)) : stall;
        for (int i = 0; i <= delay; i++) begin
            if (i > 0) begin
                next_cycle();
            end
            compare("axi_out_request_valid", 32'd1, 32'(req_valid));
            compare("axi_out_sel", 32'(e.sel), 32'(req_sel));
            compare("axi_out_base", e.base, req_base);
            compare("axi_out_burst_num", 32'(e.num), 32'(req_num));
            compare("axi_out_burst_size", 32'(e.size), 32'(req_size));
        end
        arready = 1'b1;
        next_cycle();
        arready = 1'b0;
        compare("axi_out_request_valid", 32'd0, 32'(req_valid));
        repeat (int'($urandom_range(8, 1)) - 1) next_cycle();
        finish = 1'b1;
        next_cycle();
        finish = 1'b0;
    endtask

    task automatic verify_phases(dtype_t d);
        expect_t e;
        int n;
        e = expected_request(MAT_C, shape, d, mixed);
        n = 0;
        while (!compute_en && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!compute_en) begin
            note_timeout("compute phase start");
            return;
        end
        n = 0;
        while (compute_en && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (compute_en) begin
            note_timeout("compute phase end");
            return;
        end
        compare("compute_en cycles", 32'(e.len) + 32'd1, n);
        compare("accumulate_en", 32'(d == INT4), 32'(accumulate_en));
        if (d == INT4) begin
            next_cycle();
        end
        compare("writeback_en", 32'd1, 32'(writeback_en));
        next_cycle();
        compare("writeback_en", 32'd0, 32'(writeback_en));
        compare("done", 32'd1, 32'(done));
    endtask

    task automatic run_case(shape_t s, dtype_t d, logic mx, int stall, string tag);
        int err0;
        err0 = errors;
        apply_reset();
        shape = s;
        dtype = d;
        mixed = mx;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        serve_request(MAT_C, stall);
        serve_request(MAT_A, stall);
        serve_request(MAT_B, stall);
        verify_phases(d);
        report_test($sformatf("%s%s %s mixed=%0d", tag, s.name(), d.name(), mx), err0);
    endtask

    initial begin
        int err0;
        int n;
        start    = 1'b0;
        shape    = M32K16N8;
        dtype    = FP32;
        mixed    = 1'b0;
        arready  = 1'b0;
        finish   = 1'b0;
        case_rst = 1'b0;
        void'($urandom(32'hc07ef787));

        err0 = errors;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (rst && n < TIMEOUT);
        if (rst) begin
            note_timeout("reset release");
        end
        repeat (3) begin
            next_cycle();
            compare("axi_out_request_valid", 32'd0, 32'(req_valid));
            compare("enables", 32'd0, 32'({compute_en, accumulate_en, writeback_en}));
            compare("done", 32'd0, 32'(done));
        end
        report_test("reset", err0);

        for (int s = 0; s < 3; s++) begin
            for (int d = 0; d < 4; d++) begin
                for (int m = 0; m < 2; m++) begin
                    run_case(shape_t'(s), dtype_t'(d), 1'(m), -1, "");
                end
            end
        end
        run_case(M16K16N16, FP16, 1'b1, 12, "back-pressure ");
        run_case(M8K16N32, INT4, 1'b0, -1, "before hold ");

        // Second start after done must not issue anything
        err0 = errors;
        repeat (5) begin
            next_cycle();
            compare("done", 32'd1, 32'(done));
        end
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        repeat (20) begin
            next_cycle();
            compare("axi_out_request_valid", 32'd0, 32'(req_valid));
            compare("done", 32'd1, 32'(done));
        end
        report_test("done hold", err0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end
endmodule

//--- vlog.f
+incdir+hdl
hdl/tensor_sched_pkg.sv
hdl/load_if.sv
hdl/burst_table.sv
hdl/read_requester.sv
hdl/phase_sequencer.sv
hdl/tensor_sched.sv
testbench/tb_clock.sv
testbench/tb_tensor_sched.sv
